// ==== wb_cdc_pkg.sv ====
`default_nettype none

package wb_cdc_pkg;

    // bus widths
    localparam int wb_addr_w     = 24;
    localparam int rw            = 16;
    localparam int sel_w         = 2;
    localparam int max_burst_log = 4;

    // address map
    localparam logic [wb_addr_w-1:0] local_limit = 24'h002000;  // first bridged address
    localparam int local_aw = 6;  // scratchpad aliases every 64 words
    localparam int ram_aw   = 8;
    localparam logic [wb_addr_w-ram_aw-1:0] ram_region = 16'h0020;

    // slave to master word holds data, err toggle and ack toggle
    localparam int sm_sync_w = rw + 2;

    // master to slave word holds cyc, adr, dat, we, sel, 4/8 burst and request toggle
    localparam int ms_sync_w = 1 + wb_addr_w + rw + 1 + sel_w + 2 + 1;

    // slave decodes the address as region + word index
    typedef union packed {
        logic [wb_addr_w-1:0] flat;
        struct packed {
            logic [wb_addr_w-ram_aw-1:0] region;
            logic [ram_aw-1:0]           idx;
        } f;
    } wb_addr_u;

endpackage

`default_nettype wire

// ==== ff_mb_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module ff_mb_sync #(
    parameter int data_w = 8
) (
    input  logic              src_clk,
    input  logic              dst_clk,
    input  logic              src_rst,
    input  logic              dst_rst,
    input  logic [data_w-1:0] i_data,
    input  logic              i_xfer_req,
    output logic [data_w-1:0] o_data
);

    logic [data_w-1:0] src_data;
    logic              src_tgl;
    logic [2:0]        dst_tgl;  // two sync stages plus edge detect
    logic              dst_load;

    // source side
    always_ff @(posedge src_clk) begin
        if (src_rst) begin
            src_tgl <= 1'b0;
        end else if (i_xfer_req) begin
            src_tgl <= ~src_tgl;
        end
    end

    always_ff @(posedge src_clk) begin
        if (i_xfer_req) begin
            src_data <= i_data;  // held stable until next request
        end
    end

    // destination side
    assign dst_load = dst_tgl[2] ^ dst_tgl[1];

    always_ff @(posedge dst_clk) begin
        if (dst_rst) begin
            dst_tgl <= '0;
            o_data  <= '0;
        end else begin
            dst_tgl <= {dst_tgl[1:0], src_tgl};
            if (dst_load) begin
                o_data <= src_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== wb_cross_clk.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_cross_clk import wb_cdc_pkg::*; (
    input  logic                 clk_m,
    input  logic                 clk_s,
    input  logic                 m_rst,
    input  logic                 s_rst,

    input  logic                 m_wb_cyc,
    input  logic                 m_wb_stb,
    input  logic [wb_addr_w-1:0] m_wb_adr,
    input  logic [rw-1:0]        m_wb_o_dat,
    input  logic                 m_wb_we,
    input  logic [sel_w-1:0]     m_wb_sel,
    input  logic                 m_wb_4_burst,
    input  logic                 m_wb_8_burst,
    output logic [rw-1:0]        m_wb_i_dat,
    output logic                 m_wb_ack,
    output logic                 m_wb_err,

    output logic                 s_wb_cyc,
    output logic                 s_wb_stb,
    output logic [wb_addr_w-1:0] s_wb_adr,
    output logic [rw-1:0]        s_wb_o_dat,
    output logic                 s_wb_we,
    output logic [sel_w-1:0]     s_wb_sel,
    output logic                 s_wb_4_burst,
    output logic                 s_wb_8_burst,
    input  logic [rw-1:0]        s_wb_i_dat,
    input  logic                 s_wb_ack,
    input  logic                 s_wb_err
);

    // master domain
    logic                     prev_stb;
    logic                     prev_resp;
    logic                     m_req_tgl;
    logic [max_burst_log-1:0] m_burst_cnt;
    logic [max_burst_log-1:0] m_burst_len;
    logic                     m_new_req;
    logic                     m_xfer;
    logic [ms_sync_w-1:0]     ms_src;
    logic [sm_sync_w-1:0]     sm_dst;
    logic                     msy_ack_tgl;
    logic                     msy_err_tgl;
    logic                     prev_ack_tgl;
    logic                     prev_err_tgl;
    logic                     msy_ack;
    logic                     msy_err;

    // slave domain
    logic [ms_sync_w-1:0]     ms_dst;
    logic [sm_sync_w-1:0]     sm_src;
    logic                     s_req_tgl;
    logic                     s_prev_tgl;
    logic                     s_new_req;
    logic                     s_hold;
    logic [max_burst_log-1:0] s_burst_cnt;
    logic [max_burst_log-1:0] s_burst_extra;
    logic                     s_ack_tgl;
    logic                     s_err_tgl;

    assign m_new_req = m_wb_stb & (~prev_stb | prev_resp);
    assign m_xfer    = m_new_req & (m_burst_cnt == '0);  // blocked until all acks back

    // writes always go as a single transfer
    assign m_burst_len = m_wb_we      ? max_burst_log'(1) :
                         m_wb_8_burst ? max_burst_log'(8) :
                         m_wb_4_burst ? max_burst_log'(4) : max_burst_log'(1);

    always_ff @(posedge clk_m) begin
        if (m_rst) begin
            prev_stb     <= 1'b0;
            prev_resp    <= 1'b0;
            prev_ack_tgl <= 1'b0;
            prev_err_tgl <= 1'b0;
            m_req_tgl    <= 1'b0;
            m_burst_cnt  <= '0;
        end else begin
            prev_stb     <= m_wb_stb;
            prev_resp    <= msy_ack | msy_err;
            prev_ack_tgl <= msy_ack_tgl;
            prev_err_tgl <= msy_err_tgl;
            if (m_xfer) begin
                m_req_tgl   <= ~m_req_tgl;
                m_burst_cnt <= m_burst_len;
            end else if (msy_err) begin
                m_burst_cnt <= '0;  // err ends the whole burst
            end else if (msy_ack) begin
                m_burst_cnt <= m_burst_cnt - 1'b1;
            end
        end
    end

    // toggle sent is the value after this request
    assign ms_src = {m_wb_cyc, m_wb_adr, m_wb_o_dat, m_wb_we, m_wb_sel,
                     m_wb_4_burst, m_wb_8_burst, ~m_req_tgl};

    ff_mb_sync #(
        .data_w(ms_sync_w)
    ) i_ms_sync (
        .src_clk   (clk_m),
        .dst_clk   (clk_s),
        .src_rst   (m_rst),
        .dst_rst   (s_rst),
        .i_data    (ms_src),
        .i_xfer_req(m_xfer),
        .o_data    (ms_dst)
    );

    assign {s_wb_cyc, s_wb_adr, s_wb_o_dat, s_wb_we, s_wb_sel,
            s_wb_4_burst, s_wb_8_burst, s_req_tgl} = ms_dst;

    assign s_new_req = s_req_tgl ^ s_prev_tgl;

    // beats left after the first one
    assign s_burst_extra = s_wb_we      ? '0 :
                           s_wb_8_burst ? max_burst_log'(7) :
                           s_wb_4_burst ? max_burst_log'(3) : '0;

    always_ff @(posedge clk_s) begin
        if (s_rst) begin
            s_prev_tgl  <= 1'b0;
            s_hold      <= 1'b1;  // no stb until first request lands
            s_burst_cnt <= '0;
        end else begin
            s_prev_tgl <= s_req_tgl;
            if (s_wb_err) begin
                s_burst_cnt <= '0;
                s_hold      <= 1'b1;
            end else if (s_wb_ack) begin
                if (|s_burst_cnt) begin
                    s_burst_cnt <= s_burst_cnt - 1'b1;
                end else begin
                    s_hold <= 1'b1;  // final beat
                end
            end else if (s_new_req) begin
                s_hold      <= 1'b0;
                s_burst_cnt <= s_burst_extra;
            end
        end
    end

    assign s_wb_stb = s_wb_cyc & ~s_hold;

    // ack/err travel back as toggles
    always_ff @(posedge clk_s) begin
        if (s_rst) begin
            s_ack_tgl <= 1'b0;
            s_err_tgl <= 1'b0;
        end else begin
            if (s_wb_ack) begin
                s_ack_tgl <= ~s_ack_tgl;
            end
            if (s_wb_err) begin
                s_err_tgl <= ~s_err_tgl;
            end
        end
    end

    assign sm_src = {s_wb_i_dat, s_err_tgl ^ s_wb_err, s_ack_tgl ^ s_wb_ack};

    // clk_s at least 5x slower keeps beats 3+ dst cycles apart
    ff_mb_sync #(
        .data_w(sm_sync_w)
    ) i_sm_sync (
        .src_clk   (clk_s),
        .dst_clk   (clk_m),
        .src_rst   (s_rst),
        .dst_rst   (m_rst),
        .i_data    (sm_src),
        .i_xfer_req(s_wb_ack | s_wb_err),
        .o_data    (sm_dst)
    );

    assign {m_wb_i_dat, msy_err_tgl, msy_ack_tgl} = sm_dst;

    assign msy_ack  = msy_ack_tgl ^ prev_ack_tgl;
    assign msy_err  = msy_err_tgl ^ prev_err_tgl;
    assign m_wb_ack = msy_ack;
    assign m_wb_err = msy_err;

endmodule

`default_nettype wire

// ==== wb_master_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_master_port import wb_cdc_pkg::*; (
    input  logic                 clk_m,
    input  logic                 m_rst,

    input  logic                 m_wb_cyc,
    input  logic                 m_wb_stb,
    input  logic [wb_addr_w-1:0] m_wb_adr,
    input  logic [rw-1:0]        m_wb_o_dat,
    input  logic                 m_wb_we,
    input  logic [sel_w-1:0]     m_wb_sel,
    input  logic                 m_wb_4_burst,
    input  logic                 m_wb_8_burst,
    output logic [rw-1:0]        m_wb_i_dat,
    output logic                 m_wb_ack,
    output logic                 m_wb_err,

    output logic                 br_cyc,
    output logic                 br_stb,
    output logic [wb_addr_w-1:0] br_adr,
    output logic [rw-1:0]        br_o_dat,
    output logic                 br_we,
    output logic [sel_w-1:0]     br_sel,
    output logic                 br_4_burst,
    output logic                 br_8_burst,
    input  logic [rw-1:0]        br_i_dat,
    input  logic                 br_ack,
    input  logic                 br_err
);

    logic [rw-1:0]       pad [2**local_aw];
    logic [rw-1:0]       loc_dat;
    logic                loc_ack;
    logic                loc_req;
    logic                is_local;
    logic [local_aw-1:0] loc_idx;

    assign is_local = m_wb_adr < local_limit;
    assign loc_idx  = m_wb_adr[local_aw-1:0];  // upper bits ignored so it aliases
    assign loc_req  = m_wb_cyc & m_wb_stb & is_local & ~loc_ack;

    always_ff @(posedge clk_m) begin
        if (m_rst) begin
            loc_ack <= 1'b0;
        end else begin
            loc_ack <= loc_req;
        end
    end

    always_ff @(posedge clk_m) begin
        if (loc_req) begin
            if (m_wb_we) begin
                for (int b = 0; b < sel_w; b++) begin
                    if (m_wb_sel[b]) begin
                        pad[loc_idx][b*(rw/sel_w) +: rw/sel_w] <=
                            m_wb_o_dat[b*(rw/sel_w) +: rw/sel_w];
                    end
                end
            end
            loc_dat <= pad[loc_idx];
        end
    end

    // remote requests only
    assign br_cyc     = m_wb_cyc;
    assign br_stb     = m_wb_stb & ~is_local;
    assign br_adr     = m_wb_adr;
    assign br_o_dat   = m_wb_o_dat;
    assign br_we      = m_wb_we;
    assign br_sel     = m_wb_sel;
    assign br_4_burst = m_wb_4_burst;
    assign br_8_burst = m_wb_8_burst;

    assign m_wb_i_dat = is_local ? loc_dat : br_i_dat;
    assign m_wb_ack   = is_local ? loc_ack : br_ack;
    assign m_wb_err   = ~is_local & br_err;  // scratchpad never errors

endmodule

`default_nettype wire

// ==== wb_slave_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_slave_ram import wb_cdc_pkg::*; (
    input  logic                 clk_s,
    input  logic                 s_rst,

    input  logic                 s_wb_cyc,
    input  logic                 s_wb_stb,
    input  logic [wb_addr_w-1:0] s_wb_adr,
    input  logic [rw-1:0]        s_wb_o_dat,
    input  logic                 s_wb_we,
    input  logic [sel_w-1:0]     s_wb_sel,
    input  logic                 s_wb_4_burst,
    input  logic                 s_wb_8_burst,
    output logic [rw-1:0]        s_wb_i_dat,
    output logic                 s_wb_ack,
    output logic                 s_wb_err
);

    logic [rw-1:0]            mem [2**ram_aw];
    logic [rw-1:0]            rd_dat;
    wb_addr_u                 adr_u;
    logic                     mapped;
    logic                     active;
    logic                     done;
    logic                     last;
    logic [max_burst_log-1:0] beat;
    logic [max_burst_log-1:0] last_beat;
    logic [ram_aw-1:0]        idx;

    assign adr_u  = s_wb_adr;
    assign mapped = adr_u.f.region == ram_region;
    assign idx    = adr_u.f.idx + ram_aw'(beat);  // wraps within 256

    assign last_beat = s_wb_we      ? '0 :
                       s_wb_8_burst ? max_burst_log'(7) :
                       s_wb_4_burst ? max_burst_log'(3) : '0;

    // done keeps a held stb from getting a second answer
    assign active = s_wb_cyc & s_wb_stb & ~done;
    assign last   = ~mapped | (beat == last_beat);  // err ends the burst

    always_ff @(posedge clk_s) begin
        if (s_rst) begin
            s_wb_ack <= 1'b0;
            s_wb_err <= 1'b0;
            beat     <= '0;
            done     <= 1'b0;
        end else begin
            s_wb_ack <= active & mapped;
            s_wb_err <= active & ~mapped;
            if (!(s_wb_cyc && s_wb_stb)) begin
                beat <= '0;
                done <= 1'b0;
            end else if (active) begin
                if (last) begin
                    beat <= '0;
                    done <= 1'b1;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_s) begin
        if (active && mapped) begin
            if (s_wb_we) begin
                for (int b = 0; b < sel_w; b++) begin
                    if (s_wb_sel[b]) begin
                        mem[idx][b*(rw/sel_w) +: rw/sel_w] <= s_wb_o_dat[b*(rw/sel_w) +: rw/sel_w];
                    end
                end
            end
            rd_dat <= mem[idx];
        end
    end

    assign s_wb_i_dat = rd_dat;

endmodule

`default_nettype wire

// ==== wb_cdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_cdc_top import wb_cdc_pkg::*; (
    input  logic                 clk_m,
    input  logic                 clk_s,
    input  logic                 m_rst,
    input  logic                 s_rst,

    input  logic                 m_wb_cyc,
    input  logic                 m_wb_stb,
    input  logic [wb_addr_w-1:0] m_wb_adr,
    input  logic [rw-1:0]        m_wb_o_dat,
    input  logic                 m_wb_we,
    input  logic [sel_w-1:0]     m_wb_sel,
    input  logic                 m_wb_4_burst,
    input  logic                 m_wb_8_burst,
    output logic [rw-1:0]        m_wb_i_dat,
    output logic                 m_wb_ack,
    output logic                 m_wb_err
);

    // master port to bridge
    logic                 br_cyc;
    logic                 br_stb;
    logic [wb_addr_w-1:0] br_adr;
    logic [rw-1:0]        br_o_dat;
    logic                 br_we;
    logic [sel_w-1:0]     br_sel;
    logic                 br_4_burst;
    logic                 br_8_burst;
    logic [rw-1:0]        br_i_dat;
    logic                 br_ack;
    logic                 br_err;

    // bridge to slave ram
    logic                 s_wb_cyc;
    logic                 s_wb_stb;
    logic [wb_addr_w-1:0] s_wb_adr;
    logic [rw-1:0]        s_wb_o_dat;
    logic                 s_wb_we;
    logic [sel_w-1:0]     s_wb_sel;
    logic                 s_wb_4_burst;
    logic                 s_wb_8_burst;
    logic [rw-1:0]        s_wb_i_dat;
    logic                 s_wb_ack;
    logic                 s_wb_err;

    wb_master_port i_master_port (
        .clk_m       (clk_m),
        .m_rst       (m_rst),
        .m_wb_cyc    (m_wb_cyc),
        .m_wb_stb    (m_wb_stb),
        .m_wb_adr    (m_wb_adr),
        .m_wb_o_dat  (m_wb_o_dat),
        .m_wb_we     (m_wb_we),
        .m_wb_sel    (m_wb_sel),
        .m_wb_4_burst(m_wb_4_burst),
        .m_wb_8_burst(m_wb_8_burst),
        .m_wb_i_dat  (m_wb_i_dat),
        .m_wb_ack    (m_wb_ack),
        .m_wb_err    (m_wb_err),
        .br_cyc      (br_cyc),
        .br_stb      (br_stb),
        .br_adr      (br_adr),
        .br_o_dat    (br_o_dat),
        .br_we       (br_we),
        .br_sel      (br_sel),
        .br_4_burst  (br_4_burst),
        .br_8_burst  (br_8_burst),
        .br_i_dat    (br_i_dat),
        .br_ack      (br_ack),
        .br_err      (br_err)
    );

    wb_cross_clk i_cross_clk (
        .clk_m       (clk_m),
        .clk_s       (clk_s),
        .m_rst       (m_rst),
        .s_rst       (s_rst),
        .m_wb_cyc    (br_cyc),
        .m_wb_stb    (br_stb),
        .m_wb_adr    (br_adr),
        .m_wb_o_dat  (br_o_dat),
        .m_wb_we     (br_we),
        .m_wb_sel    (br_sel),
        .m_wb_4_burst(br_4_burst),
        .m_wb_8_burst(br_8_burst),
        .m_wb_i_dat  (br_i_dat),
        .m_wb_ack    (br_ack),
        .m_wb_err    (br_err),
        .s_wb_cyc    (s_wb_cyc),
        .s_wb_stb    (s_wb_stb),
        .s_wb_adr    (s_wb_adr),
        .s_wb_o_dat  (s_wb_o_dat),
        .s_wb_we     (s_wb_we),
        .s_wb_sel    (s_wb_sel),
        .s_wb_4_burst(s_wb_4_burst),
        .s_wb_8_burst(s_wb_8_burst),
        .s_wb_i_dat  (s_wb_i_dat),
        .s_wb_ack    (s_wb_ack),
        .s_wb_err    (s_wb_err)
    );

    wb_slave_ram i_slave_ram (
        .clk_s       (clk_s),
        .s_rst       (s_rst),
        .s_wb_cyc    (s_wb_cyc),
        .s_wb_stb    (s_wb_stb),
        .s_wb_adr    (s_wb_adr),
        .s_wb_o_dat  (s_wb_o_dat),
        .s_wb_we     (s_wb_we),
        .s_wb_sel    (s_wb_sel),
        .s_wb_4_burst(s_wb_4_burst),
        .s_wb_8_burst(s_wb_8_burst),
        .s_wb_i_dat  (s_wb_i_dat),
        .s_wb_ack    (s_wb_ack),
        .s_wb_err    (s_wb_err)
    );

endmodule

`default_nettype wire

// ==== tb_wb_cdc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_cdc import wb_cdc_pkg::*; ();

    localparam int resp_timeout = 2000;  // clk_m cycles per wait
    localparam int quiet_cycles = 24;

    typedef struct packed {
        logic                 we;
        logic [wb_addr_w-1:0] adr;
        logic [3:0]           burst;  // 0, 4 or 8
        logic [sel_w-1:0]     sel;
        logic                 exp_err;
    } op_t;

    logic                 clk_m = 1'b0;
    logic                 clk_s = 1'b0;
    logic                 m_rst;
    logic                 s_rst;
    logic                 m_wb_cyc;
    logic                 m_wb_stb;
    logic [wb_addr_w-1:0] m_wb_adr;
    logic [rw-1:0]        m_wb_o_dat;
    logic                 m_wb_we;
    logic [sel_w-1:0]     m_wb_sel;
    logic                 m_wb_4_burst;
    logic                 m_wb_8_burst;
    logic [rw-1:0]        m_wb_i_dat;
    logic                 m_wb_ack;
    logic                 m_wb_err;

    logic [rw-1:0]        pad_model [2**local_aw];
    logic [rw-1:0]        ram_model [2**ram_aw];
    op_t                  ops [$];
    logic [31:0]          lfsr;
    int                   value_errs;
    int                   resp_errs;
    int                   other_errs;
    logic                 stalled;

    always #5 clk_m = ~clk_m;
    always #25 clk_s = ~clk_s;  // 5x slower than clk_m

    wb_cdc_top i_dut (
        .clk_m       (clk_m),
        .clk_s       (clk_s),
        .m_rst       (m_rst),
        .s_rst       (s_rst),
        .m_wb_cyc    (m_wb_cyc),
        .m_wb_stb    (m_wb_stb),
        .m_wb_adr    (m_wb_adr),
        .m_wb_o_dat  (m_wb_o_dat),
        .m_wb_we     (m_wb_we),
        .m_wb_sel    (m_wb_sel),
        .m_wb_4_burst(m_wb_4_burst),
        .m_wb_8_burst(m_wb_8_burst),
        .m_wb_i_dat  (m_wb_i_dat),
        .m_wb_ack    (m_wb_ack),
        .m_wb_err    (m_wb_err)
    );

    // galois lfsr, one step per bit taken
    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'ha3000000;
        end
        return b;
    endfunction

    function automatic logic [rw-1:0] rand_word();
        logic [rw-1:0] w;
        w = '0;
        for (int i = 0; i < rw; i++) begin
            w = {w[rw-2:0], next_bit()};
        end
        return w;
    endfunction

    function automatic logic [rw-1:0] merge(input logic [rw-1:0] old,
                                            input logic [rw-1:0] dat,
                                            input logic [sel_w-1:0] sel);
        logic [rw-1:0] w;
        w = old;
        for (int b = 0; b < sel_w; b++) begin
            if (sel[b]) begin
                w[b*8 +: 8] = dat[b*8 +: 8];
            end
        end
        return w;
    endfunction

    // reference memories; the local scratchpad aliases every 64 words
    function automatic logic [rw-1:0] model_read(input logic [wb_addr_w-1:0] adr,
                                                 input int beat);
        wb_addr_u          u;
        logic [ram_aw-1:0] i;
        u.flat = adr;
        i      = u.f.idx + ram_aw'(beat);  // burst wraps within 256
        if (adr < local_limit) begin
            return pad_model[adr[local_aw-1:0]];
        end
        return ram_model[i];
    endfunction

    task automatic model_write(input logic [wb_addr_w-1:0] adr, input logic [rw-1:0] dat,
                               input logic [sel_w-1:0] sel);
        wb_addr_u u;
        u.flat = adr;
        if (adr < local_limit) begin
            pad_model[adr[local_aw-1:0]] = merge(pad_model[adr[local_aw-1:0]], dat, sel);
        end else if (u.f.region == ram_region) begin
            ram_model[u.f.idx] = merge(ram_model[u.f.idx], dat, sel);
        end
    endtask

    task automatic check_data(input string tag, input logic [rw-1:0] got,
                              input logic [rw-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %0t m_wb_i_dat (%s) got %h expected %h", $time, tag, got, exp);
        end
    endtask

    task automatic check_resp(input string tag, input logic got_ack, got_err,
                              exp_ack, exp_err);
        if ({got_ack, got_err} !== {exp_ack, exp_err}) begin
            resp_errs++;
            $display("[FAIL] %0t m_wb_ack/m_wb_err (%s) got %b/%b expected %b/%b",
                     $time, tag, got_ack, got_err, exp_ack, exp_err);
        end
    endtask

    task automatic expect_quiet(input string tag, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk_m);
            #1;
            check_resp(tag, m_wb_ack, m_wb_err, 1'b0, 1'b0);
        end
    endtask

    // one bus cycle, called 1 ns after a clk_m edge
    task automatic run_op(input string tag, input op_t op);
        int   beats;
        int   beat;
        int   waited;
        logic got;
        logic done;
        beats = 1;
        if (!op.we && op.burst == 4'd4) begin
            beats = 4;
        end else if (!op.we && op.burst == 4'd8) begin
            beats = 8;
        end
        m_wb_cyc     = 1'b1;
        m_wb_stb     = 1'b1;
        m_wb_adr     = op.adr;
        m_wb_o_dat   = op.we ? rand_word() : '0;
        m_wb_we      = op.we;
        m_wb_sel     = op.sel;
        m_wb_4_burst = (op.burst == 4'd4);
        m_wb_8_burst = (op.burst == 4'd8);
        beat = 0;
        done = 1'b0;
        while (!done) begin
            waited = 0;
            got    = 1'b0;
            while (!got && waited < resp_timeout) begin
                @(posedge clk_m);
                #1;
                waited++;
                got = m_wb_ack | m_wb_err;
            end
            if (!got) begin
                other_errs++;
                stalled = 1'b1;
                done    = 1'b1;
                $display("%s stalled: beat %0d saw no ack or err within %0d clk_m cycles",
                         tag, beat, resp_timeout);
            end else begin
                check_resp(tag, m_wb_ack, m_wb_err, ~op.exp_err, op.exp_err);
                if (!op.we && m_wb_ack && !op.exp_err) begin
                    check_data(tag, m_wb_i_dat, model_read(op.adr, beat));
                end
                beat++;
                done = m_wb_err || (beat == beats);
            end
        end
        if (op.we) begin
            model_write(op.adr, m_wb_o_dat, op.sel);  // unmapped leaves model alone
        end
        m_wb_cyc     = 1'b0;  // stb drops right after the final ack
        m_wb_stb     = 1'b0;
        m_wb_we      = 1'b0;
        m_wb_4_burst = 1'b0;
        m_wb_8_burst = 1'b0;
        if (!stalled) begin
            expect_quiet(tag, quiet_cycles);  // no second ack or err
        end
    endtask

    task automatic add_op(input logic we, input logic [wb_addr_w-1:0] adr,
                          input logic [3:0] burst, input logic [sel_w-1:0] sel,
                          input logic exp_err);
        op_t o;
        o.we      = we;
        o.adr     = adr;
        o.burst   = burst;
        o.sel     = sel;
        o.exp_err = exp_err;
        ops.push_back(o);
    endtask

    task automatic build_table();
        // scratchpad with partial selects and aliasing
        add_op(1'b1, 24'h000010, 4'd0, 2'b01, 1'b0);
        add_op(1'b0, 24'h000010, 4'd0, 2'b11, 1'b0);
        add_op(1'b1, 24'h000011, 4'd0, 2'b10, 1'b0);
        add_op(1'b0, 24'h000011, 4'd0, 2'b11, 1'b0);
        add_op(1'b0, 24'h000050, 4'd0, 2'b11, 1'b0);  // alias of 0x10
        add_op(1'b0, 24'h001fd1, 4'd0, 2'b11, 1'b0);  // alias of 0x11
        add_op(1'b1, 24'h000c03, 4'd0, 2'b11, 1'b0);
        add_op(1'b0, 24'h000003, 4'd0, 2'b11, 1'b0);
        // remote singles
        add_op(1'b1, 24'h002005, 4'd0, 2'b11, 1'b0);
        add_op(1'b0, 24'h002005, 4'd0, 2'b11, 1'b0);
        add_op(1'b1, 24'h002006, 4'd0, 2'b01, 1'b0);
        add_op(1'b0, 24'h002006, 4'd0, 2'b11, 1'b0);
        add_op(1'b1, 24'h0020a0, 4'd0, 2'b10, 1'b0);
        add_op(1'b0, 24'h0020a0, 4'd0, 2'b11, 1'b0);
        // read bursts where two of them wrap at 256
        add_op(1'b0, 24'h002010, 4'd4, 2'b11, 1'b0);
        add_op(1'b0, 24'h002040, 4'd8, 2'b11, 1'b0);
        add_op(1'b0, 24'h0020fe, 4'd4, 2'b11, 1'b0);
        add_op(1'b0, 24'h0020fc, 4'd8, 2'b11, 1'b0);
        add_op(1'b1, 24'h002011, 4'd4, 2'b11, 1'b0);  // write burst flag, one beat
        add_op(1'b0, 24'h002010, 4'd4, 2'b11, 1'b0);
        add_op(1'b1, 24'h002080, 4'd8, 2'b01, 1'b0);
        add_op(1'b0, 24'h00207e, 4'd4, 2'b11, 1'b0);
        // unmapped remote
        add_op(1'b1, 24'h002105, 4'd0, 2'b11, 1'b1);
        add_op(1'b0, 24'h002105, 4'd0, 2'b11, 1'b1);
        add_op(1'b1, 24'h003005, 4'd0, 2'b11, 1'b1);
        add_op(1'b1, 24'hffff05, 4'd0, 2'b10, 1'b1);
        add_op(1'b0, 24'h002105, 4'd8, 2'b11, 1'b1);
        add_op(1'b0, 24'h002005, 4'd0, 2'b11, 1'b0);  // same index, must be unchanged
        add_op(1'b0, 24'h002000, 4'd8, 2'b11, 1'b0);
        add_op(1'b0, 24'h000010, 4'd0, 2'b11, 1'b0);
    endtask

    initial begin
        s_rst = 1'b1;
        repeat (3) @(posedge clk_s);
        #1;
        s_rst = 1'b0;
    end

    initial begin
        int  waited;
        op_t op;
        m_rst        = 1'b1;
        m_wb_cyc     = 1'b0;
        m_wb_stb     = 1'b0;
        m_wb_adr     = '0;
        m_wb_o_dat   = '0;
        m_wb_we      = 1'b0;
        m_wb_sel     = '0;
        m_wb_4_burst = 1'b0;
        m_wb_8_burst = 1'b0;
        lfsr         = 32'h76f45d92;
        value_errs   = 0;
        resp_errs    = 0;
        other_errs   = 0;
        stalled      = 1'b0;
        build_table();

        repeat (3) @(posedge clk_m);
        #1;
        m_rst  = 1'b0;
        waited = 0;
        while (s_rst && waited < resp_timeout) begin
            @(posedge clk_m);
            #1;
            waited++;
        end
        if (s_rst) begin
            other_errs++;
            stalled = 1'b1;
            $display("slave reset was still asserted after %0d clk_m cycles", resp_timeout);
        end

        expect_quiet("idle after reset", 40);

        // both memories start unknown
        op.burst   = 4'd0;
        op.sel     = 2'b11;
        op.exp_err = 1'b0;
        op.we      = 1'b1;
        for (int i = 0; i < 2**local_aw && !stalled; i++) begin
            op.adr = wb_addr_w'(i);
            run_op($sformatf("scratchpad fill %0d", i), op);
        end
        for (int i = 0; i < 2**ram_aw && !stalled; i++) begin
            op.adr = {ram_region, ram_aw'(i)};
            run_op($sformatf("ram fill %0d", i), op);
        end

        for (int n = 0; n < ops.size() && !stalled; n++) begin
            run_op($sformatf("entry %0d", n), ops[n]);
        end

        $display("errors: value=%0d response=%0d other=%0d", value_errs, resp_errs, other_errs);
        if (value_errs + resp_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
wb_cdc_pkg.sv
ff_mb_sync.sv
wb_cross_clk.sv
wb_master_port.sv
wb_slave_ram.sv
wb_cdc_top.sv
tb_wb_cdc.sv

// ==== Bender.yml ====
package:
  name: wb_cdc

sources:
  - wb_cdc_pkg.sv
  - ff_mb_sync.sv
  - wb_cross_clk.sv
  - wb_master_port.sv
  - wb_slave_ram.sv
  - wb_cdc_top.sv
  - target: simulation
    files:
      - tb_wb_cdc.sv
